//--- sources.f
hw/xc_pkg.sv
hw/delay_line.sv
hw/coincidence_counter.sv
hw/correlator_core.sv
hw/frame_capture.sv
hw/axil_regs.sv
hw/xc_top.sv
testbench/xc_checker.sv
testbench/xc_asserts.sv
testbench/tb_xc.sv

//--- run_sim.sh
#!/bin/sh
# builds the correlator testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_xc \
	-f sources.f -o sim_xc
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_xc > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0

//--- testbench/tb_xc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xc;
	import xc_pkg::*;

	localparam int num_entries = 7;
	localparam logic [1:0] pat_rand = 2'd0;
	localparam logic [1:0] pat_lag = 2'd1; // line 0 then line 1, one cycle each.
	localparam logic [1:0] pat_ones = 2'd2;

	typedef struct packed {
		logic [15:0] len;
		logic [1:0] kind;
		logic [31:0] seed;
	} entry_t;

	logic intclk;
	logic reset;
	logic [num_inputs-1:0] line_in;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	entry_t entries [num_entries];
	int checker_errors;
	int checker_checks;
	int tb_errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	xc_top dut_i (
		.intclk(intclk),
		.reset(reset),
		.line_in(line_in),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp)
	);

	xc_checker checker_i (
		.intclk(intclk),
		.reset(reset),
		.line_in(line_in),
		.integrating(dut_i.integrating),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.errors(checker_errors),
		.checks(checker_checks)
	);

	initial begin
		intclk = 1'b0;
		forever #10 intclk = ~intclk;
	end

	always @(posedge intclk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [3:0] next_sample(input logic [1:0] kind, input int idx,
			input logic [31:0] rnd);
		case (kind)
			pat_lag: return (idx == 0) ? 4'b0001 : (idx == 1) ? 4'b0010 : 4'b0000;
			pat_ones: return 4'b1111;
			default: return rnd[7:4];
		endcase
	endfunction

	// hold > 0 keeps bready low for that many cycles once bvalid is up.
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int hold);
		@(posedge intclk);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr <= addr;
		axil_req.wvalid <= 1'b1;
		axil_req.wdata <= data;
		axil_req.wstrb <= strb;
		axil_req.bready <= (hold == 0);
		do @(posedge intclk); while (!axil_rsp.awready);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		do @(posedge intclk); while (!axil_rsp.bvalid);
		if (hold > 0) begin
			repeat (hold) @(posedge intclk);
			axil_req.bready <= 1'b1;
			@(posedge intclk);
		end
		axil_req.bready <= 1'b0;
	endtask

	// hold > 0 keeps rready low for that many cycles once rvalid is up.
	task automatic read_reg(input logic [7:0] addr, input int hold, output logic [31:0] data);
		@(posedge intclk);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr <= addr;
		axil_req.rready <= (hold == 0);
		do @(posedge intclk); while (!axil_rsp.arready);
		axil_req.arvalid <= 1'b0;
		do @(posedge intclk); while (!axil_rsp.rvalid);
		if (hold > 0) begin
			repeat (hold) @(posedge intclk);
			axil_req.rready <= 1'b1;
			@(posedge intclk);
		end
		data = axil_rsp.rdata;
		axil_req.rready <= 1'b0;
	endtask

	task automatic read_counts();
		logic [31:0] data;
		for (int i = 0; i < num_counts; i++)
			read_reg(reg_count_base + 8'(4 * i), 0, data);
	endtask

	task automatic run_window(input int e);
		logic [31:0] data;
		logic [31:0] rnd;
		int len_eff;
		len_eff = (entries[e].len == 0) ? 1 : int'(entries[e].len);
		rnd = entries[e].seed;
		write_reg(reg_len, 32'(entries[e].len), 4'b0011, 0);
		write_reg(reg_ctrl, 32'h1, 4'b0001, 0);
		fork
			for (int i = 0; i < len_eff; i++) begin
				rnd = xorshift(rnd);
				line_in <= next_sample(entries[e].kind, i, rnd);
				@(posedge intclk);
			end
			if (len_eff >= 40) begin
				repeat (4) @(posedge intclk);
				write_reg(reg_ctrl, 32'h1, 4'b0001, 0); // lands mid-window.
				read_reg(reg_status, 0, data);
				read_reg(reg_count_base, 0, data); // still the previous frame.
			end
		join
		line_in <= '0;
		do read_reg(reg_status, 3, data); while (data[0] || !data[1]);
		if (data[31:16] !== 16'(e + 1)) begin
			tb_errors++;
			$display("FAIL frame_num: expected %h got %h", 16'(e + 1), data[31:16]);
		end
		read_counts();
	endtask

	initial begin
		logic [31:0] data;
		reset = 1'b1;
		line_in = '0;
		axil_req = '0;
		entries[0] = '{16'd40, pat_rand, 32'h2fa6_c081};
		entries[1] = '{16'd0, pat_rand, 32'h2fa6_c081 ^ 32'h0000_1111};
		entries[2] = '{16'd100, pat_rand, 32'h2fa6_c081 ^ 32'h0022_0000};
		entries[3] = '{16'd8, pat_lag, 32'h0};
		entries[4] = '{16'd12, pat_ones, 32'h0};
		entries[5] = '{16'd65535, pat_ones, 32'h0}; // longest window, full scale.
		entries[6] = '{16'd57, pat_rand, 32'h2fa6_c081 ^ 32'h3300_0000};
		cycle_limit = 200 * (num_entries + 1);
		for (int e = 0; e < num_entries; e++)
			cycle_limit += (entries[e].len == 0) ? 1 : int'(entries[e].len);
		repeat (3) @(posedge intclk);
		reset <= 1'b0;

		read_reg(reg_status, 0, data);
		read_reg(reg_len, 0, data);
		read_counts();
		write_reg(reg_len, 32'hffff_ff05, 4'b0001, 3); // low byte only.
		read_reg(reg_len, 4, data);
		write_reg(8'h90, 32'h1, 4'b1111, 0);
		read_reg(8'h80, 0, data);
		read_reg(8'h06, 0, data);

		for (int e = 0; e < num_entries; e++)
			run_window(e);

		repeat (2) @(posedge intclk);
		$display("closing: %0d bus checks, %0d checker errors, %0d testbench errors",
			checker_checks, checker_errors, tb_errors);
		if (checker_errors == 0 && tb_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/xc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module xc_asserts (
	input wire logic intclk,
	input wire logic reset,
	input wire xc_pkg::axil_req_t axil_req,
	input wire xc_pkg::axil_rsp_t axil_rsp,
	input wire logic start,
	input wire logic busy
);

	bvalid_hold: assert property (@(posedge intclk) disable iff (reset)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge intclk) disable iff (reset)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
		else $error("read data dropped or changed while waiting for rready");

	start_idle: assert property (@(posedge intclk) disable iff (reset)
		start |-> !busy)
		else $error("start pulse while a window is running");

endmodule

bind axil_regs xc_asserts asserts_i (
	.intclk(intclk),
	.reset(reset),
	.axil_req(axil_req),
	.axil_rsp(axil_rsp),
	.start(start),
	.busy(busy)
);

`default_nettype wire

//--- testbench/xc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module xc_checker (
	input wire logic intclk,
	input wire logic reset,
	input wire logic [xc_pkg::num_inputs-1:0] line_in,
	input wire logic integrating,
	input wire xc_pkg::axil_req_t axil_req,
	input wire xc_pkg::axil_rsp_t axil_rsp,
	output int errors,
	output int checks
);
	import xc_pkg::*;

	int live [num_counts]; // counts of the running window.
	int frozen [num_counts]; // last snapshot.
	int win_cycles; // integrating cycles of the running window.
	int win_len_model; // expected window cycles.
	logic [num_inputs-1:0] prev;
	logic integ_prev;
	logic ready_model;
	logic [15:0] fnum_model;
	logic [15:0] len_model;
	logic [31:0] rd_word;
	logic [1:0] rd_resp;
	logic [7:0] rd_addr;
	logic [1:0] wr_resp;

	function automatic int sat_add(input int value, input logic hit);
		return (hit && value < 65535) ? value + 1 : value;
	endfunction

	function automatic logic is_mapped(input logic [7:0] addr);
		return addr == 8'h00 || addr == 8'h04 || addr == 8'h08 ||
			(addr >= 8'h10 && addr < 8'h10 + 4 * num_counts && addr[1:0] == 2'b00);
	endfunction

	function automatic logic [31:0] expected_word(input logic [7:0] addr, input logic busy_now);
		if (addr == 8'h04)
			return {16'h0, len_model};
		if (addr == 8'h08)
			return {fnum_model, 14'h0, ready_model, busy_now};
		if (addr >= 8'h10 && is_mapped(addr))
			return 32'(frozen[(addr - 8'h10) / 4]);
		return 32'h0; // ctrl and unmapped.
	endfunction

	always @(posedge intclk) begin
		int p;
		int base;
		logic busy_now;
		if (reset) begin
			for (int i = 0; i < num_counts; i++) begin
				live[i] = 0;
				frozen[i] = 0;
			end
			prev = '0;
			integ_prev = 1'b0;
			ready_model = 1'b0;
			fnum_model = '0;
			len_model = 16'd16;
			win_cycles = 0;
			win_len_model = 0;
			errors = 0;
			checks = 0;
		end else begin
			if (integrating && !integ_prev) begin // window just opened.
				for (int i = 0; i < num_counts; i++)
					live[i] = 0;
				prev = '0;
				ready_model = 1'b0;
				win_cycles = 0;
				win_len_model = (len_model == 16'h0) ? 1 : int'(len_model); // 0 runs as 1.
			end
			busy_now = integrating || integ_prev; // snapshot cycle counts as busy.
			if (axil_rsp.arready) begin
				rd_addr = axil_req.araddr;
				rd_word = expected_word(axil_req.araddr, busy_now);
				rd_resp = is_mapped(axil_req.araddr) ? 2'd0 : 2'd2;
			end
			if (axil_rsp.rvalid && axil_req.rready) begin
				checks++;
				if (axil_rsp.rdata !== rd_word || axil_rsp.rresp !== rd_resp) begin
					errors++;
					$display("FAIL rdata/rresp at addr %h: expected %h/%h got %h/%h", rd_addr,
						rd_word, rd_resp, axil_rsp.rdata, axil_rsp.rresp);
				end
			end
			if (axil_rsp.awready) begin
				wr_resp = is_mapped(axil_req.awaddr) ? 2'd0 : 2'd2;
				if (axil_req.awaddr == 8'h04) begin
					for (int b = 0; b < 2; b++)
						if (axil_req.wstrb[b])
							len_model[8 * b +: 8] = axil_req.wdata[8 * b +: 8];
				end
			end
			if (axil_rsp.bvalid && axil_req.bready) begin
				checks++;
				if (axil_rsp.bresp !== wr_resp) begin
					errors++;
					$display("FAIL bresp: expected %h got %h", wr_resp, axil_rsp.bresp);
				end
			end
			if (integrating) begin
				win_cycles++;
				for (int n = 0; n < num_inputs; n++) begin
					live[2 * n] = sat_add(live[2 * n], line_in[n]);
					live[2 * n + 1] = sat_add(live[2 * n + 1], line_in[n] & prev[n]);
				end
				p = 0;
				for (int a = 0; a < num_inputs - 1; a++) begin
					for (int b = a + 1; b < num_inputs; b++) begin
						base = 8 + 3 * p;
						live[base] = sat_add(live[base], prev[a] & line_in[b]); // lag -1.
						live[base + 1] = sat_add(live[base + 1], line_in[a] & line_in[b]);
						live[base + 2] = sat_add(live[base + 2], line_in[a] & prev[b]);
						p++;
					end
				end
				prev = line_in;
			end
			if (integ_prev && !integrating) begin // snapshot edge.
				checks++;
				if (win_cycles != win_len_model) begin
					errors++;
					$display("FAIL integrating cycles: expected %h got %h", win_len_model,
						win_cycles);
				end
				frozen = live;
				fnum_model = fnum_model + 1'b1;
				ready_model = 1'b1;
			end
			integ_prev = integrating;
		end
	end

endmodule

`default_nettype wire

//--- hw/xc_top.sv
`timescale 1ns/1ps
`default_nettype none

module xc_top (
	input wire logic intclk,
	input wire logic reset,
	input wire logic [xc_pkg::num_inputs-1:0] line_in,
	input wire xc_pkg::axil_req_t axil_req,
	output xc_pkg::axil_rsp_t axil_rsp
);
	import xc_pkg::*;

	logic start;
	logic [len_width-1:0] win_len;
	logic integrating;
	logic clear;
	logic busy;
	logic frame_ready;
	count_t [num_counts-1:0] counts; // live counter array.
	frame_t frame; // last frozen window.

	correlator_core core_i (
		.intclk(intclk),
		.reset(reset),
		.clear(clear),
		.integrating(integrating),
		.line_in(line_in),
		.counts(counts)
	);

	frame_capture capture_i (
		.intclk(intclk),
		.reset(reset),
		.start(start),
		.win_len(win_len),
		.counts(counts),
		.integrating(integrating),
		.clear(clear),
		.busy(busy),
		.frame_ready(frame_ready),
		.frame(frame)
	);

	axil_regs regs_i (
		.intclk(intclk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.frame(frame),
		.busy(busy),
		.frame_ready(frame_ready),
		.start(start),
		.win_len(win_len)
	);

endmodule

`default_nettype wire

//--- hw/axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_regs (
	input wire logic intclk,
	input wire logic reset,
	input wire xc_pkg::axil_req_t axil_req,
	output xc_pkg::axil_rsp_t axil_rsp,
	input wire xc_pkg::frame_t frame,
	input wire logic busy,
	input wire logic frame_ready,
	output logic start,
	output logic [xc_pkg::len_width-1:0] win_len
);
	import xc_pkg::*;

	localparam int idx_width = $clog2(num_counts);
	localparam logic [axil_addr_width-1:0] count_end =
		reg_count_base + axil_addr_width'(4 * num_counts);

	logic wr_take; // write address and data taken together.
	logic rd_take;
	logic bvalid;
	logic rvalid;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic [axil_data_width-1:0] rdata;
	logic [axil_data_width-1:0] rd_word; // read mux output.
	logic [axil_addr_width-1:0] rd_off;
	logic start_req;

	function automatic logic addr_mapped(input logic [axil_addr_width-1:0] addr);
		logic in_counts;
		in_counts = (addr >= reg_count_base) && (addr < count_end);
		return (addr[1:0] == 2'b00) &&
			((addr == reg_ctrl) || (addr == reg_len) || (addr == reg_status) || in_counts);
	endfunction

	assign wr_take = axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign rd_take = axil_req.arvalid && !rvalid;

	assign start_req = (axil_req.awaddr == reg_ctrl) && axil_req.wstrb[0] &&
		axil_req.wdata[0] && !busy; // ignored mid-window.

	always_comb begin
		rd_off = axil_req.araddr - reg_count_base;
		rd_word = '0;
		case (axil_req.araddr)
			reg_ctrl: rd_word = '0; // ctrl has no readable state.
			reg_len: rd_word = axil_data_width'(win_len);
			reg_status: begin
				rd_word[31:16] = frame.frame_num;
				rd_word[1] = frame_ready;
				rd_word[0] = busy;
			end
			default: begin
				if (addr_mapped(axil_req.araddr)) begin
					rd_word = axil_data_width'(frame.counts[rd_off[2 +: idx_width]]);
				end
			end
		endcase
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			bvalid <= 1'b0;
			start <= 1'b0;
			win_len <= len_default;
		end else begin
			start <= 1'b0; // one cycle pulse.
			if (wr_take) begin
				bvalid <= 1'b1;
				start <= start_req;
				if (axil_req.awaddr == reg_len) begin
					for (int i = 0; i < len_width / 8; i++) begin
						if (axil_req.wstrb[i]) begin
							win_len[8 * i +: 8] <= axil_req.wdata[8 * i +: 8];
						end
					end
				end
			end else if (axil_req.bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (rd_take) begin
			rvalid <= 1'b1;
		end else if (axil_req.rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge intclk) begin
		if (wr_take) begin
			bresp <= addr_mapped(axil_req.awaddr) ? resp_okay : resp_slverr;
		end
		if (rd_take) begin
			rdata <= rd_word; // held until rready.
			rresp <= addr_mapped(axil_req.araddr) ? resp_okay : resp_slverr;
		end
	end

	always_comb begin
		axil_rsp.awready = wr_take;
		axil_rsp.wready = wr_take;
		axil_rsp.bvalid = bvalid;
		axil_rsp.bresp = bresp;
		axil_rsp.arready = rd_take;
		axil_rsp.rvalid = rvalid;
		axil_rsp.rdata = rdata;
		axil_rsp.rresp = rresp;
	end

endmodule

`default_nettype wire

//--- hw/frame_capture.sv
`timescale 1ns/1ps
`default_nettype none

module frame_capture (
	input wire logic intclk,
	input wire logic reset,
	input wire logic start,
	input wire logic [xc_pkg::len_width-1:0] win_len,
	input wire xc_pkg::count_t [xc_pkg::num_counts-1:0] counts,
	output logic integrating,
	output logic clear,
	output logic busy,
	output logic frame_ready,
	output xc_pkg::frame_t frame
);
	import xc_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_integ,
		s_snap
	} state_t;

	state_t state;
	logic [len_width-1:0] remaining; // samples left in the window.

	assign integrating = (state == s_integ);
	assign busy = (state != s_idle);
	assign clear = start && (state == s_idle); // zeroes the core as integration opens.

	always_ff @(posedge intclk) begin
		if (reset) begin
			state <= s_idle;
			remaining <= '0;
			frame_ready <= 1'b0;
			frame <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (start) begin
						state <= s_integ;
						remaining <= (win_len == '0) ? len_width'(1) : win_len; // 0 runs as 1.
						frame_ready <= 1'b0;
					end
				end
				s_integ: begin
					remaining <= remaining - 1'b1;
					if (remaining == len_width'(1)) begin
						state <= s_snap;
					end
				end
				s_snap: begin
					// counters hold their final values here.
					frame.counts <= counts;
					frame.frame_num <= frame.frame_num + 1'b1;
					frame_ready <= 1'b1;
					state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/correlator_core.sv
`timescale 1ns/1ps
`default_nettype none

module correlator_core (
	input wire logic intclk,
	input wire logic reset,
	input wire logic clear,
	input wire logic integrating,
	input wire logic [xc_pkg::num_inputs-1:0] line_in,
	output xc_pkg::count_t [xc_pkg::num_counts-1:0] counts
);
	import xc_pkg::*;

	localparam int cross_base = num_inputs * lag_auto; // first cross count index.

	logic [delay_depth-1:0] taps [num_inputs];
	logic [num_counts-1:0] hits; // lag products in count order.

	for (genvar n = 0; n < num_inputs; n++) begin : g_line
		delay_line delay_i (
			.intclk(intclk),
			.reset(reset),
			.clear(clear),
			.shift(integrating), // only window samples enter the line.
			.sample(line_in[n]),
			.taps(taps[n])
		);

		for (genvar k = 0; k < lag_auto; k++) begin : g_auto
			assign hits[n * lag_auto + k] = taps[n][0] & taps[n][k]; // x[t]*x[t-k].
		end
	end

	// pairs run (0,1),(0,2),(0,3),(1,2),(1,3),(2,3).
	for (genvar a = 0; a < num_inputs - 1; a++) begin : g_a
		for (genvar b = a + 1; b < num_inputs; b++) begin : g_b
			localparam int pair = a * (2 * num_inputs - a - 1) / 2 + (b - a - 1);

			for (genvar l = 0; l < cross_lags; l++) begin : g_lag
				localparam int lag = l - (lag_cross - 1);
				localparam int tap_a = (lag < 0) ? -lag : 0; // negative lag delays a.
				localparam int tap_b = (lag > 0) ? lag : 0; // positive lag delays b.

				assign hits[cross_base + pair * cross_lags + l] =
					taps[a][tap_a] & taps[b][tap_b];
			end
		end
	end

	for (genvar i = 0; i < num_counts; i++) begin : g_count
		coincidence_counter counter_i (
			.intclk(intclk),
			.reset(reset),
			.clear(clear),
			.hit(hits[i] & integrating),
			.count(counts[i])
		);
	end

endmodule

`default_nettype wire

//--- hw/coincidence_counter.sv
`timescale 1ns/1ps
`default_nettype none

module coincidence_counter (
	input wire logic intclk,
	input wire logic reset,
	input wire logic clear,
	input wire logic hit,
	output xc_pkg::count_t count
);

	logic at_max; // counter pinned at full scale.

	assign at_max = &count;

	always_ff @(posedge intclk) begin
		if (reset || clear) begin
			count <= '0;
		end else if (hit && !at_max) begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module delay_line (
	input wire logic intclk,
	input wire logic reset,
	input wire logic clear,
	input wire logic shift,
	input wire logic sample,
	output logic [xc_pkg::delay_depth-1:0] taps
);
	import xc_pkg::*;

	logic [delay_depth-2:0] hist; // older samples, newest in bit 0.

	// tap k is the sample from k cycles back.
	assign taps = {hist, sample};

	always_ff @(posedge intclk) begin
		if (reset || clear) begin
			hist <= '0; // first sample of a window sees zeros behind it.
		end else if (shift) begin
			hist[0] <= sample;
			for (int i = 1; i < delay_depth - 1; i++) begin
				hist[i] <= hist[i - 1];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/xc_pkg.sv
`default_nettype none

package xc_pkg;

	localparam int num_inputs = 4;
	localparam int lag_auto = 2; // lags 0 and 1.
	localparam int lag_cross = 2;
	localparam int cross_lags = 2 * lag_cross - 1; // lags -1, 0, +1.
	localparam int num_baselines = num_inputs * (num_inputs - 1) / 2;
	localparam int delay_depth = 2; // live sample plus one older.
	localparam int num_counts = num_inputs * lag_auto + num_baselines * cross_lags;
	localparam int count_width = 16;
	localparam int len_width = 16;
	localparam int fnum_width = 16;

	localparam int axil_addr_width = 8;
	localparam int axil_data_width = 32;

	// register map, byte addresses.
	localparam logic [axil_addr_width-1:0] reg_ctrl = 8'h00;
	localparam logic [axil_addr_width-1:0] reg_len = 8'h04;
	localparam logic [axil_addr_width-1:0] reg_status = 8'h08;
	localparam logic [axil_addr_width-1:0] reg_count_base = 8'h10;

	localparam logic [1:0] resp_okay = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

	localparam logic [len_width-1:0] len_default = 16; // window length after reset.

	typedef logic [count_width-1:0] count_t;

	typedef struct packed {
		count_t [num_counts-1:0] counts;
		logic [fnum_width-1:0] frame_num;
	} frame_t;

	typedef struct packed {
		logic awvalid;
		logic [axil_addr_width-1:0] awaddr;
		logic wvalid;
		logic [axil_data_width-1:0] wdata;
		logic [axil_data_width/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [axil_addr_width-1:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [axil_data_width-1:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire
